/* design/coef_stage.sv */
`timescale 1ns/1ps

module coef_stage import esprit_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  cov_s  cov,
    input  logic  cov_valid,
    output coef_s coef,
    output logic  coef_valid
);

    // lambda^2 + b*lambda + c = 0, with b = -(r11+r22), c = r11*r22 - r12^2

    logic signed [2*COV_W-1:0] rr_full;
    logic signed [2*COV_W-1:0] qq_full;
    coef_t r_sum;

    // stage 1
    coef_t rr1;
    coef_t qq1;
    coef_t b1;
    cov_t r11_1;
    cov_t r12_1;

    // stage 2
    logic signed [2*COEF_W-1:0] bb_full;
    coef_t c2;
    coef_t bb2;
    coef_t b2;
    cov_t r11_2;
    cov_t r12_2;

    logic [2:0] vld;

    assign rr_full = cov.r11 * cov.r22;
    assign qq_full = cov.r12 * cov.r12;
    assign r_sum = cov.r11 + cov.r22;
    assign bb_full = b1 * b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[1:0], cov_valid};
        end
    end

    assign coef_valid = vld[2];

    // products back to 16 fractional bits
    always_ff @(posedge clk) begin
        rr1 <= coef_t'(rr_full >>> FRAC);
        qq1 <= coef_t'(qq_full >>> FRAC);
        b1 <= -r_sum;
        r11_1 <= cov.r11;
        r12_1 <= cov.r12;
    end

    // c and b squared
    always_ff @(posedge clk) begin
        c2 <= rr1 - qq1;
        bb2 <= coef_t'(bb_full >>> FRAC);
        b2 <= b1;
        r11_2 <= r11_1;
        r12_2 <= r12_1;
    end

    // discriminant b^2 - 4c, r11/r12 travel with it for the eigenvector
    always_ff @(posedge clk) begin
        coef.b <= b2;
        coef.disc <= bb2 - (c2 <<< 2);
        coef.r11 <= r11_2;
        coef.r12 <= r12_2;
    end

endmodule

/* design/cov_accum.sv */
`timescale 1ns/1ps

module cov_accum import esprit_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  snap_s snap,
    input  logic  snap_valid,
    output cov_s  cov,
    output logic  cov_valid
);

    // snapshot index within the current block
    logic [SNAPS_LOG2:0] cnt;

    // product register stage
    logic signed [PROD_W-1:0] p11;
    logic signed [PROD_W-1:0] p22;
    logic signed [PROD_W-1:0] p12;
    logic prod_valid;
    logic prod_last;

    // running block sums
    logic signed [ACC_W-1:0] acc11;
    logic signed [ACC_W-1:0] acc22;
    logic signed [ACC_W-1:0] acc12;
    logic signed [ACC_W-1:0] sum11;
    logic signed [ACC_W-1:0] sum22;
    logic signed [ACC_W-1:0] sum12;

    assign sum11 = acc11 + p11;
    assign sum22 = acc22 + p22;
    assign sum12 = acc12 + p12;

    // count accepted snapshots, tag the one that closes the block
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
            prod_valid <= 1'b0;
            prod_last <= 1'b0;
        end else begin
            prod_valid <= snap_valid;
            if (snap_valid) begin
                prod_last <= (cnt == SNAPS - 1);
                cnt <= (cnt == SNAPS - 1) ? '0 : cnt + 1'b1;
            end
        end
    end

    // full-width products, only the valid strobe qualifies them
    always_ff @(posedge clk) begin
        if (snap_valid) begin
            p11 <= snap.ant0 * snap.ant0;
            p22 <= snap.ant1 * snap.ant1;
            p12 <= snap.ant0 * snap.ant1;
        end
    end

    // accumulate; reset throws away a partial block
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc11 <= '0;
            acc22 <= '0;
            acc12 <= '0;
            cov_valid <= 1'b0;
        end else begin
            cov_valid <= prod_valid & prod_last;
            if (prod_valid) begin
                acc11 <= prod_last ? '0 : sum11;
                acc22 <= prod_last ? '0 : sum22;
                acc12 <= prod_last ? '0 : sum12;
            end
        end
    end

    // block average: shift realigns the binary point and divides by SNAPS
    always_ff @(posedge clk) begin
        if (prod_valid && prod_last) begin
            cov.r11 <= cov_t'(sum11 >>> AVG_SHIFT);
            cov.r22 <= cov_t'(sum22 >>> AVG_SHIFT);
            cov.r12 <= cov_t'(sum12 >>> AVG_SHIFT);
        end
    end

    // the block must close before the index runs past the last snapshot
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt < SNAPS);

endmodule

/* design/eigen_out.sv */
`timescale 1ns/1ps

module eigen_out import esprit_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  root_s root,
    input  logic  root_valid,
    output eig_s  eig,
    output logic  eig_valid
);

    // eigenvector components y = lambda - r11, one bit of headroom before clamping
    logic signed [COEF_W:0] d1;
    logic signed [COEF_W:0] d2;

    assign d1 = root.lamb1 - root.r11;
    assign d2 = root.lamb2 - root.r11;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eig_valid <= 1'b0;
        end else begin
            eig_valid <= root_valid;
        end
    end

    // x stays r12 as is, the angle stage divides y by it
    always_ff @(posedge clk) begin
        eig.lamb1 <= sat_eig(root.lamb1);
        eig.lamb2 <= sat_eig(root.lamb2);
        eig.vec1_y <= sat_eig(d1);
        eig.vec2_y <= sat_eig(d2);
        eig.vec_x <= eig_t'(root.r12);
        eig.err <= root.err;
    end

    // a flagged discriminant means a zero root upstream, so both eigenvalues coincide
    a_err_equal: assert property (@(posedge clk) disable iff (!rst_n)
        eig_valid && eig.err |-> eig.lamb1 == eig.lamb2);

endmodule

/* design/esprit_eigen.sv */
`timescale 1ns/1ps

module esprit_eigen import esprit_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  snap_s snap,
    input  logic  snap_valid,
    output eig_s  eig,
    output logic  eig_valid
);

    cov_s cov;
    logic cov_valid;
    coef_s coef;
    logic coef_valid;
    root_s root;
    logic root_valid;

    // block covariance, one result per 16 snapshots
    cov_accum i_cov_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .snap       (snap),
        .snap_valid (snap_valid),
        .cov        (cov),
        .cov_valid  (cov_valid)
    );

    // b, c and discriminant, 3 cycles
    coef_stage i_coef_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .cov        (cov),
        .cov_valid  (cov_valid),
        .coef       (coef),
        .coef_valid (coef_valid)
    );

    // square root and both eigenvalues, 19 cycles
    quad_root i_quad_root (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef       (coef),
        .coef_valid (coef_valid),
        .root       (root),
        .root_valid (root_valid)
    );

    eigen_out i_eigen_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .root       (root),
        .root_valid (root_valid),
        .eig        (eig),
        .eig_valid  (eig_valid)
    );

endmodule

/* design/esprit_pkg.sv */
package esprit_pkg;

    // snapshot format: signed, 11 fractional bits
    localparam int SAMPLE_W = 12;
    localparam int SNAPS = 16;
    localparam int SNAPS_LOG2 = 4;

    // every internal value carries 16 fractional bits
    localparam int FRAC = 16;
    localparam int COV_W = 18;
    localparam int COEF_W = 20;
    localparam int ROOT_W = 18;
    localparam int SQRT_STAGES = 18;
    localparam int EIG_W = 18;

    // full-width snapshot product and block accumulator
    localparam int PROD_W = 2 * SAMPLE_W;
    localparam int ACC_W = PROD_W + SNAPS_LOG2;
    // product has 22 fractional bits, drop down to FRAC and divide by SNAPS
    localparam int AVG_SHIFT = 2 * (SAMPLE_W - 1) - FRAC + SNAPS_LOG2;

    // square root radicand and working remainder widths
    localparam int RAD_W = 2 * ROOT_W;
    localparam int REM_W = ROOT_W + 3;

    // output clamp limits, held one bit wider than a coefficient
    localparam logic signed [COEF_W:0] SAT_HI = 2 ** (EIG_W - 1) - 1;
    localparam logic signed [COEF_W:0] SAT_LO = -(2 ** (EIG_W - 1));

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COV_W-1:0] cov_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic [ROOT_W-1:0] root_t;
    typedef logic signed [EIG_W-1:0] eig_t;

    // one snapshot from both antennas
    typedef struct packed {
        sample_t ant0;
        sample_t ant1;
    } snap_s;

    // block-averaged covariance terms
    typedef struct packed {
        cov_t r11;
        cov_t r22;
        cov_t r12;
    } cov_s;

    // quadratic coefficient, discriminant and the terms needed for the eigenvector
    typedef struct packed {
        coef_t b;
        coef_t disc;
        cov_t r11;
        cov_t r12;
    } coef_s;

    // both roots at coefficient width, still unsaturated
    typedef struct packed {
        coef_t lamb1;
        coef_t lamb2;
        cov_t r11;
        cov_t r12;
        logic err;
    } root_s;

    typedef struct packed {
        eig_t lamb1;
        eig_t lamb2;
        eig_t vec1_y;
        eig_t vec2_y;
        eig_t vec_x;
        logic err;
    } eig_s;

    // clamp a value to the signed output range
    function automatic eig_t sat_eig(input logic signed [COEF_W:0] v);
        if (v > SAT_HI) begin
            return eig_t'(SAT_HI);
        end
        if (v < SAT_LO) begin
            return eig_t'(SAT_LO);
        end
        return eig_t'(v);
    endfunction

endpackage

/* design/quad_root.sv */
`timescale 1ns/1ps

module quad_root import esprit_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  coef_s coef,
    input  logic  coef_valid,
    output root_s root,
    output logic  root_valid
);

    // one square-root step with everything the item carries alongside
    typedef struct packed {
        coef_t b;
        cov_t r11;
        cov_t r12;
        logic err;
        logic [RAD_W-1:0] rad;
        root_t q;
        logic signed [REM_W-1:0] rem;
    } stage_s;

    stage_s head;
    stage_s s_in [SQRT_STAGES];
    stage_s s_nx [SQRT_STAGES];
    stage_s s_q [SQRT_STAGES];
    stage_s last;

    logic signed [REM_W-1:0] rem_sh [SQRT_STAGES];
    logic signed [REM_W-1:0] trial [SQRT_STAGES];
    logic signed [REM_W-1:0] diff [SQRT_STAGES];

    // valid bit per stage plus the final root register
    logic [SQRT_STAGES:0] v;

    logic signed [COEF_W+1:0] b_ext;
    logic signed [COEF_W+1:0] s_ext;
    logic signed [COEF_W+1:0] sum_p;
    logic signed [COEF_W+1:0] sum_m;

    // negative discriminant: flag it and take the root of zero
    always_comb begin
        head.b = coef.b;
        head.r11 = coef.r11;
        head.r12 = coef.r12;
        head.err = coef.disc[COEF_W-1];
        head.rad = head.err ? '0 : (RAD_W'($unsigned(coef.disc)) << FRAC);
        head.q = '0;
        head.rem = '0;
    end

    // restoring digit-by-digit root, two radicand bits per stage
    always_comb begin
        s_in[0] = head;
        for (int k = 1; k < SQRT_STAGES; k++) begin
            s_in[k] = s_q[k-1];
        end
        for (int k = 0; k < SQRT_STAGES; k++) begin
            rem_sh[k] = {s_in[k].rem[REM_W-3:0], s_in[k].rad[RAD_W-1 -: 2]};
            // trial subtrahend is 4q + 1
            trial[k] = $signed({1'b0, s_in[k].q, 2'b01});
            diff[k] = rem_sh[k] - trial[k];
            s_nx[k] = s_in[k];
            s_nx[k].rad = s_in[k].rad << 2;
            if (!diff[k][REM_W-1]) begin
                s_nx[k].q = {s_in[k].q[ROOT_W-2:0], 1'b1};
                s_nx[k].rem = diff[k];
            end else begin
                s_nx[k].q = {s_in[k].q[ROOT_W-2:0], 1'b0};
                s_nx[k].rem = rem_sh[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        s_q <= s_nx;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v <= '0;
        end else begin
            v <= {v[SQRT_STAGES-1:0], coef_valid};
        end
    end

    // roots (-b +/- s) / 2, two guard bits so the sums cannot wrap
    assign last = s_q[SQRT_STAGES-1];
    assign b_ext = last.b;
    assign s_ext = {{(COEF_W+2-ROOT_W){1'b0}}, last.q};
    assign sum_p = s_ext - b_ext;
    assign sum_m = -b_ext - s_ext;

    always_ff @(posedge clk) begin
        root.lamb1 <= coef_t'(sum_p >>> 1);
        root.lamb2 <= coef_t'(sum_m >>> 1);
        root.r11 <= last.r11;
        root.r12 <= last.r12;
        root.err <= last.err;
    end

    assign root_valid = v[SQRT_STAGES];

    // a valid item never leaves a stage with a negative remainder
    for (genvar k = 0; k < SQRT_STAGES; k++) begin : g_rem_chk
        a_rem_pos: assert property (@(posedge clk) disable iff (!rst_n)
            v[k] |-> !s_q[k].rem[REM_W-1]);
    end

endmodule

/* dv/tb_esprit_eigen.sv */
`timescale 1ns/1ps

module tb_esprit_eigen import esprit_pkg::*; ();

    // test sizes in blocks plus one block cut short by reset
    localparam int N_FULL = 24;
    localparam int N_GAP = 16;
    localparam int N_EQUAL = 8;
    localparam int N_FRESH = 2;
    localparam int N_BLOCKS = N_FULL + N_GAP + N_EQUAL + N_FRESH + 1;
    localparam int MAX_CYCLES = 40 * N_BLOCKS + 200;
    // edge of the last snapshot to eig_valid
    localparam int LATENCY = 24;
    localparam logic [31:0] SEED = 32'hc07a4464;

    logic clk;
    logic rst_n;
    snap_s snap;
    logic snap_valid;
    eig_s eig;
    logic eig_valid;

    logic [31:0] lfsr;
    int cycle;
    string test_name;

    // model block sums and expected results in pipeline order
    longint acc11;
    longint acc22;
    longint acc12;
    int n_taken;
    eig_s exp_q[$];
    int due_q[$];
    eig_s exp_e;
    int exp_due;

    esprit_eigen i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .snap       (snap),
        .snap_valid (snap_valid),
        .eig        (eig),
        .eig_valid  (eig_valid)
    );

    always #10 clk = ~clk;

    // cycle count that also bounds the run
    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: run still going after %0d cycles", MAX_CYCLES));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    function automatic sample_t random_sample();
        return sample_t'(rand_bits(SAMPLE_W));
    endfunction

    // keep the low w bits as a signed value
    function automatic longint wrap_to(input longint v, input int w);
        longint m;
        m = v & ((longint'(1) << w) - 1);
        if (m >= (longint'(1) << (w - 1))) begin
            m = m - (longint'(1) << w);
        end
        return m;
    endfunction

    function automatic eig_t clamp_eig(input longint v);
        longint hi;
        longint lo;
        hi = (longint'(1) << (EIG_W - 1)) - 1;
        lo = -(longint'(1) << (EIG_W - 1));
        if (v > hi) begin
            return eig_t'(hi);
        end
        if (v < lo) begin
            return eig_t'(lo);
        end
        return eig_t'(v);
    endfunction

    // floor square root picked greedily from the top bit
    function automatic longint isqrt_floor(input longint rad);
        longint q;
        longint t;
        q = 0;
        for (int bit_i = ROOT_W - 1; bit_i >= 0; bit_i--) begin
            t = q | (longint'(1) << bit_i);
            if (t * t <= rad) begin
                q = t;
            end
        end
        return q;
    endfunction

    // eigenvalues of [r11 r12; r12 r22] from the block sums
    function automatic eig_s model_block(input longint s11, input longint s22,
                                         input longint s12);
        longint r11;
        longint r22;
        longint r12;
        longint rr;
        longint qq;
        longint b;
        longint c;
        longint bb;
        longint disc;
        longint s;
        longint l1;
        longint l2;
        int avg;
        eig_s e;
        // products carry 22 fractional bits that come down to FRAC in the block average
        avg = 2 * (SAMPLE_W - 1) - FRAC + SNAPS_LOG2;
        r11 = wrap_to(s11 >>> avg, COV_W);
        r22 = wrap_to(s22 >>> avg, COV_W);
        r12 = wrap_to(s12 >>> avg, COV_W);
        rr = wrap_to((r11 * r22) >>> FRAC, COEF_W);
        qq = wrap_to((r12 * r12) >>> FRAC, COEF_W);
        b = wrap_to(-(r11 + r22), COEF_W);
        c = wrap_to(rr - qq, COEF_W);
        bb = wrap_to((b * b) >>> FRAC, COEF_W);
        disc = wrap_to(bb - 4 * c, COEF_W);
        e.err = (disc < 0);
        // negative discriminant gives a zero root
        s = e.err ? 0 : isqrt_floor(disc << FRAC);
        l1 = wrap_to((s - b) >>> 1, COEF_W);
        l2 = wrap_to((-b - s) >>> 1, COEF_W);
        e.lamb1 = clamp_eig(l1);
        e.lamb2 = clamp_eig(l2);
        e.vec1_y = clamp_eig(l1 - r11);
        e.vec2_y = clamp_eig(l2 - r11);
        e.vec_x = eig_t'(r12);
        return e;
    endfunction

    task automatic reset_model();
        acc11 = 0;
        acc22 = 0;
        acc12 = 0;
        n_taken = 0;
        exp_q.delete();
        due_q.delete();
    endtask

    // the 16th snapshot is sampled on the next edge and its result is due LATENCY later
    task automatic take_snapshot(input sample_t a0, input sample_t a1);
        acc11 += longint'(a0) * longint'(a0);
        acc22 += longint'(a1) * longint'(a1);
        acc12 += longint'(a0) * longint'(a1);
        n_taken++;
        if (n_taken == SNAPS) begin
            exp_q.push_back(model_block(acc11, acc22, acc12));
            due_q.push_back(cycle + 1 + LATENCY);
            acc11 = 0;
            acc22 = 0;
            acc12 = 0;
            n_taken = 0;
        end
    endtask

    task automatic drive_snap(input sample_t a0, input sample_t a1, input logic vld);
        @(posedge clk);
        #1;
        snap.ant0 = a0;
        snap.ant1 = a1;
        snap_valid = vld;
        if (vld) begin
            take_snapshot(a0, a1);
        end
    endtask

    task automatic drive_idle();
        drive_snap('0, '0, 1'b0);
    endtask

    task automatic check_eig(input string field, input eig_t exp, input eig_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s %s expected %0d actual %0d",
                                test_name, field, exp, act));
        end
    endtask

    task automatic check_flag(input string field, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s %s expected %b actual %b",
                                test_name, field, exp, act));
        end
    endtask

    task automatic check_timing(input string field, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("Error: %s %s expected %0d actual %0d",
                                test_name, field, exp, act));
        end
    endtask

    task automatic check_missing();
        if (exp_q.size() != 0) begin
            abort_run($sformatf("missing output: %0d expected results never came in %s",
                                exp_q.size(), test_name));
        end
    endtask

    // once the pipeline has emptied every expected result must have come out
    task automatic settle();
        repeat (LATENCY + 8) drive_idle();
        check_missing();
    endtask

    // synchronous reset with model and queues cleared on the edge the DUT clears
    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        snap_valid = 1'b0;
        @(posedge clk);
        #1;
        reset_model();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // outputs are read half a cycle after the edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (eig_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("eig_valid pulsed with no result expected in %s",
                                        test_name));
                end
                exp_e = exp_q.pop_front();
                exp_due = due_q.pop_front();
                check_timing("eig_valid cycle", exp_due, cycle);
                check_eig("lamb1", exp_e.lamb1, eig.lamb1);
                check_eig("lamb2", exp_e.lamb2, eig.lamb2);
                check_eig("vec1_y", exp_e.vec1_y, eig.vec1_y);
                check_eig("vec2_y", exp_e.vec2_y, eig.vec2_y);
                check_eig("vec_x", exp_e.vec_x, eig.vec_x);
                check_flag("err", exp_e.err, eig.err);
            end else if (eig_valid !== 1'b0) begin
                abort_run("eig_valid is unknown while out of reset");
            end
        end
    end

    // back to back blocks with snap_valid high every cycle
    task automatic run_full_rate();
        sample_t a0;
        sample_t a1;
        test_name = "full_rate";
        repeat (N_FULL * SNAPS) begin
            a0 = random_sample();
            a1 = random_sample();
            drive_snap(a0, a1, 1'b1);
        end
    endtask

    // one lfsr bit per cycle decides whether a snapshot is offered
    task automatic run_gaps();
        sample_t a0;
        sample_t a1;
        test_name = "gaps";
        repeat (N_GAP * SNAPS) begin
            while (rand_bits(1) == 0) begin
                drive_idle();
            end
            a0 = random_sample();
            a1 = random_sample();
            drive_snap(a0, a1, 1'b1);
        end
    endtask

    // rank one covariance gives lamb2 near zero and the first block runs at full scale
    task automatic run_equal();
        sample_t a;
        logic [1:0] sh;
        test_name = "equal_antennas";
        for (int blk = 0; blk < N_EQUAL; blk++) begin
            sh = 2'(rand_bits(2));
            repeat (SNAPS) begin
                if (blk == 0) begin
                    a = sample_t'(12'h800);
                end else begin
                    a = random_sample();
                    a = a >>> sh;
                end
                drive_snap(a, a, 1'b1);
            end
        end
    endtask

    // partial block dropped by reset and fresh blocks afterwards
    task automatic run_reset_mid_block();
        sample_t a0;
        sample_t a1;
        test_name = "reset_mid_block";
        repeat (9) begin
            a0 = random_sample();
            a1 = random_sample();
            drive_snap(a0, a1, 1'b1);
        end
        apply_reset();
        repeat (LATENCY + 8) drive_idle();
        repeat (N_FRESH * SNAPS) begin
            a0 = random_sample();
            a1 = random_sample();
            drive_snap(a0, a1, 1'b1);
        end
        settle();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        snap = '0;
        snap_valid = 1'b0;
        lfsr = SEED;
        cycle = 0;
        test_name = "reset";
        reset_model();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // eig_valid has to stay low while nothing is offered
        test_name = "idle_after_reset";
        repeat (LATENCY + 8) drive_idle();
        run_full_rate();
        settle();
        run_gaps();
        settle();
        run_equal();
        settle();
        run_reset_mid_block();
        if (exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            check_missing();
        end
    end

endmodule

/* esprit_eigen.f */
design/esprit_pkg.sv
design/cov_accum.sv
design/coef_stage.sv
design/quad_root.sv
design/eigen_out.sv
design/esprit_eigen.sv
dv/tb_esprit_eigen.sv

/* run_sim.sh */
#!/bin/sh
# build and run the esprit_eigen testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_esprit_eigen \
    --Mdir obj_dir -o sim_esprit_eigen \
    -f esprit_eigen.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_esprit_eigen
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
